//--- rtl/alu_defs.svh
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

`define ALU_DATA_W 32
`define ALU_ADDR_W 5

`define REG_OP0    5'h00
`define REG_OP1    5'h04
`define REG_IMM    5'h08
`define REG_CMD    5'h0C
`define REG_RESULT 5'h10
`define REG_FLAGS  5'h14
`define REG_STATUS 5'h18

`define CMD_OP_LSB  0
`define CMD_W_LSB   8
`define CMD_IMM_BIT 12

`define AXI_OKAY   2'b00
`define AXI_SLVERR 2'b10

`endif

//--- rtl/alu_pkg.sv
package alu_pkg;

    // operations kept from the execution stage
    typedef enum logic [5:0] {
        ALU_MOVE = 6'd0,
        ALU_ADD  = 6'd1,
        ALU_ADC  = 6'd2,
        ALU_SUB  = 6'd3,
        ALU_SBC  = 6'd4,
        ALU_CP   = 6'd5,
        ALU_AND  = 6'd6,
        ALU_OR   = 6'd7,
        ALU_XOR  = 6'd8,
        ALU_NEG  = 6'd9,
        ALU_CPL  = 6'd10,
        ALU_BIT  = 6'd11,
        ALU_CHG  = 6'd12,
        ALU_BS1F = 6'd13,
        ALU_BS1B = 6'd14,
        ALU_MIRR = 6'd15,
        ALU_EXTS = 6'd16,
        ALU_EXTZ = 6'd17,
        ALU_CCF  = 6'd18,
        ALU_SCF  = 6'd19,
        ALU_RCF  = 6'd20,
        ALU_DJNZ = 6'd21
    } alu_op_e;

    typedef enum logic [1:0] {
        W_BYTE = 2'd0,
        W_WORD = 2'd1,
        W_LONG = 2'd2   // 2'd3 behaves as long too
    } alu_width_e;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RESP  = 2'd1,   // write response pending
        RDATA = 2'd2    // read data pending
    } axil_state_e;

    // bit positions in the flag byte, bits 3 and 5 read as zero
    typedef enum int {
        FLAG_C = 0,
        FLAG_N = 1,
        FLAG_V = 2,
        FLAG_H = 4,
        FLAG_Z = 6,
        FLAG_S = 7
    } flag_bit_e;

endpackage

//--- rtl/alu_cmd_if.sv
`timescale 1ns/100ps
`include "alu_defs.svh"

interface alu_cmd_if;
    import alu_pkg::*;

    logic                   start;     // one cycle per command
    alu_op_e                op;
    alu_width_e             width;
    logic                   sel_imm;   // imm replaces op1
    logic [`ALU_DATA_W-1:0] op0;
    logic [`ALU_DATA_W-1:0] op1;
    logic [`ALU_DATA_W-1:0] imm;

    logic [`ALU_DATA_W-1:0] result;
    logic [7:0]             flags;
    logic                   djnz_zero;
    logic                   done;      // cycle after start

    modport regs (
        output start, op, width, sel_imm, op0, op1, imm,
        input  result, flags, djnz_zero, done
    );

    modport core (
        input  start, op, width, sel_imm, op0, op1, imm,
        output result, flags, djnz_zero, done
    );

endinterface

//--- rtl/alu_regs.sv
`timescale 1ns/100ps
`include "alu_defs.svh"

module alu_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`ALU_ADDR_W-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`ALU_DATA_W-1:0]   wdata,
    input  logic [`ALU_DATA_W/8-1:0] wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [`ALU_ADDR_W-1:0]   araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [`ALU_DATA_W-1:0]   rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    alu_cmd_if.regs                  cmd
);
    import alu_pkg::*;

    axil_state_e            wr_state;
    axil_state_e            rd_state;
    logic                   wr_fire;
    logic                   wr_ok;
    logic                   rd_ok;
    logic                   start_q;
    logic                   done_sticky;
    logic [`ALU_DATA_W-1:0] rd_word;
    logic [`ALU_DATA_W-1:0] cmd_word;
    logic [`ALU_DATA_W-1:0] op0_q, op1_q, imm_q;
    alu_op_e                op_q;
    alu_width_e             width_q;
    logic                   sel_imm_q;

    // byte lanes follow wstrb
    function automatic logic [`ALU_DATA_W-1:0] merge(
        input logic [`ALU_DATA_W-1:0]   old_val,
        input logic [`ALU_DATA_W-1:0]   new_val,
        input logic [`ALU_DATA_W/8-1:0] strb
    );
        logic [`ALU_DATA_W-1:0] r;
        r = old_val;
        for (int b = 0; b < `ALU_DATA_W/8; b++) begin
            if (strb[b])
                r[8*b +: 8] = new_val[8*b +: 8];
        end
        return r;
    endfunction

    assign wr_fire = (wr_state == IDLE) && awready; // valids are held until ready

    always_comb begin
        case (awaddr)
            `REG_OP0, `REG_OP1, `REG_IMM, `REG_CMD: wr_ok = 1'b1;
            default:                                wr_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            case (awaddr)
                `REG_OP0: op0_q <= merge(op0_q, wdata, wstrb);
                `REG_OP1: op1_q <= merge(op1_q, wdata, wstrb);
                `REG_IMM: imm_q <= merge(imm_q, wdata, wstrb);
                `REG_CMD: begin
                    op_q      <= alu_op_e'(wdata[`CMD_OP_LSB +: 6]);
                    width_q   <= alu_width_e'(wdata[`CMD_W_LSB +: 2]);
                    sel_imm_q <= wdata[`CMD_IMM_BIT];
                end
                default: ;   // read-only or unmapped
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_state    <= IDLE;
            awready     <= 1'b0;
            wready      <= 1'b0;
            bvalid      <= 1'b0;
            bresp       <= `AXI_OKAY;
            start_q     <= 1'b0;
            done_sticky <= 1'b0;
        end else begin
            start_q <= wr_fire && (awaddr == `REG_CMD);
            if (wr_fire && (awaddr == `REG_CMD))
                done_sticky <= 1'b0;
            else if (cmd.done)
                done_sticky <= 1'b1;
            case (wr_state)
                IDLE: begin
                    if (awready) begin
                        awready  <= 1'b0;
                        wready   <= 1'b0;
                        bvalid   <= 1'b1;
                        bresp    <= wr_ok ? `AXI_OKAY : `AXI_SLVERR;
                        wr_state <= RESP;
                    end else if (awvalid && wvalid) begin
                        awready <= 1'b1;
                        wready  <= 1'b1;
                    end
                end
                RESP: begin
                    if (bready) begin
                        bvalid   <= 1'b0;
                        wr_state <= IDLE;
                    end
                end
                default: wr_state <= IDLE;
            endcase
        end
    end

    always_comb begin
        cmd_word = '0;
        cmd_word[`CMD_OP_LSB +: 6] = op_q;
        cmd_word[`CMD_W_LSB +: 2]  = width_q;
        cmd_word[`CMD_IMM_BIT]     = sel_imm_q;
        rd_ok = 1'b1;
        case (araddr)
            `REG_OP0:    rd_word = op0_q;
            `REG_OP1:    rd_word = op1_q;
            `REG_IMM:    rd_word = imm_q;
            `REG_CMD:    rd_word = cmd_word;
            `REG_RESULT: rd_word = cmd.result;
            `REG_FLAGS:  rd_word = {{(`ALU_DATA_W-8){1'b0}}, cmd.flags};
            `REG_STATUS: rd_word = {{(`ALU_DATA_W-2){1'b0}}, cmd.djnz_zero,
                                    done_sticky | cmd.done};
            default: begin
                rd_word = '0;
                rd_ok   = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_state <= IDLE;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            rresp    <= `AXI_OKAY;
            rdata    <= '0;
        end else begin
            case (rd_state)
                IDLE: begin
                    if (arready) begin
                        arready  <= 1'b0;
                        rvalid   <= 1'b1;
                        rdata    <= rd_word;
                        rresp    <= rd_ok ? `AXI_OKAY : `AXI_SLVERR;
                        rd_state <= RDATA;
                    end else if (arvalid) begin
                        arready <= 1'b1;
                    end
                end
                RDATA: begin
                    if (rready) begin   // rdata holds until taken
                        rvalid   <= 1'b0;
                        rd_state <= IDLE;
                    end
                end
                default: rd_state <= IDLE;
            endcase
        end
    end

    assign cmd.start   = start_q;
    assign cmd.op      = op_q;
    assign cmd.width   = width_q;
    assign cmd.sel_imm = sel_imm_q;
    assign cmd.op0     = op0_q;
    assign cmd.op1     = op1_q;
    assign cmd.imm     = imm_q;

endmodule

//--- rtl/alu_core.sv
`timescale 1ns/100ps
`include "alu_defs.svh"

module alu_core (
    input  logic    clk,
    input  logic    rst,
    alu_cmd_if.core cmd
);
    import alu_pkg::*;

    alu_width_e             w;
    logic [`ALU_DATA_W-1:0] op2, lhs, rhs;
    logic [`ALU_DATA_W-1:0] rslt, result_q;
    logic [32:0]            ext_lhs, ext_rhs, ext_rslt;
    logic [2:0]             cc;        // carries out of bits 7, 15 and 31
    logic                   h4;        // carry out of bit 3
    logic                   cin;
    logic                   is_sub;
    logic [7:0]             nx_flags, flag_q;
    logic                   nx_djnz, djnz_q;
    logic                   done_q;

    function automatic logic msb_at(input logic [31:0] x, input alu_width_e wd);
        if (wd == W_BYTE)
            return x[7];
        else if (wd == W_WORD)
            return x[15];
        return x[31];
    endfunction

    function automatic logic zero_at(input logic [31:0] x, input alu_width_e wd);
        if (wd == W_BYTE)
            return x[7:0] == 8'd0;
        else if (wd == W_WORD)
            return x[15:0] == 16'd0;
        return x == 32'd0;
    endfunction

    // sign extension to 33 bits for the overflow check
    function automatic logic [32:0] extend(input logic [31:0] x, input alu_width_e wd);
        if (wd == W_BYTE)
            return {{25{x[7]}}, x[7:0]};
        else if (wd == W_WORD)
            return {{17{x[15]}}, x[15:0]};
        return {x[31], x};
    endfunction

    // nibble, byte and halfword adder, subtract adds the inverse and flips carries to borrows
    function automatic logic [35:0] add_chain(
        input logic [31:0] a,
        input logic [31:0] b,
        input logic        ci,
        input logic        sub
    );
        logic [31:0] bb;
        logic [31:0] r;
        logic        h, c0, c1, c2;
        bb = sub ? ~b : b;
        {h,  r[3:0]}   = {1'b0, a[3:0]}   + {1'b0, bb[3:0]}   + {4'd0, ci ^ sub};
        {c0, r[7:4]}   = {1'b0, a[7:4]}   + {1'b0, bb[7:4]}   + {4'd0, h};
        {c1, r[15:8]}  = {1'b0, a[15:8]}  + {1'b0, bb[15:8]}  + {8'd0, c0};
        {c2, r[31:16]} = {1'b0, a[31:16]} + {1'b0, bb[31:16]} + {16'd0, c1};
        return {c2 ^ sub, c1 ^ sub, c0 ^ sub, h ^ sub, r};
    endfunction

    assign w   = cmd.width;
    assign op2 = cmd.sel_imm ? cmd.imm : cmd.op1;

    always_comb begin
        rslt     = result_q;
        nx_flags = flag_q;
        nx_djnz  = djnz_q;
        lhs      = cmd.op0;
        rhs      = op2;
        cin      = 1'b0;
        is_sub   = 1'b0;
        cc       = 3'd0;
        h4       = 1'b0;
        ext_lhs  = '0;
        ext_rhs  = '0;
        ext_rslt = '0;
        case (cmd.op)
            ALU_MOVE: rslt = op2;
            ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP, ALU_NEG: begin
                is_sub = cmd.op inside {ALU_SUB, ALU_SBC, ALU_CP, ALU_NEG};
                cin    = (cmd.op inside {ALU_ADC, ALU_SBC}) && flag_q[FLAG_C];
                if (cmd.op == ALU_NEG) begin   // 0 - op0
                    lhs = '0;
                    rhs = cmd.op0;
                end
                {cc, h4, rslt} = add_chain(lhs, rhs, cin, is_sub);
                ext_lhs  = extend(lhs, w);
                ext_rhs  = extend(rhs, w);
                ext_rslt = is_sub ? ext_lhs - ext_rhs - {32'd0, cin}
                                  : ext_lhs + ext_rhs + {32'd0, cin};
                nx_flags[FLAG_S] = msb_at(rslt, w);
                nx_flags[FLAG_Z] = zero_at(rslt, w);
                nx_flags[FLAG_H] = h4;
                nx_flags[FLAG_V] = ext_rslt[32] ^ msb_at(rslt, w);
                nx_flags[FLAG_N] = is_sub;
                nx_flags[FLAG_C] = (w == W_BYTE) ? cc[0] : (w == W_WORD) ? cc[1] : cc[2];
                if (cmd.op == ALU_CP)
                    rslt = result_q;   // compare only
            end
            ALU_AND, ALU_OR, ALU_XOR: begin
                rslt = (cmd.op == ALU_AND) ? cmd.op0 & op2 :
                       (cmd.op == ALU_OR)  ? cmd.op0 | op2 : cmd.op0 ^ op2;
                nx_flags[FLAG_S] = msb_at(rslt, w);
                nx_flags[FLAG_Z] = zero_at(rslt, w);
                nx_flags[FLAG_H] = cmd.op == ALU_AND;
                nx_flags[FLAG_V] = (w == W_BYTE) ? ~^rslt[7:0] : ~^rslt[15:0];
                nx_flags[FLAG_N] = 1'b0;
                nx_flags[FLAG_C] = 1'b0;
            end
            ALU_CPL: begin
                rslt = ~op2;
                nx_flags[FLAG_H] = 1'b1;
                nx_flags[FLAG_N] = 1'b1;
            end
            ALU_BIT: begin
                nx_flags[FLAG_Z] = ~cmd.op1[cmd.imm[3:0]];
                nx_flags[FLAG_N] = 1'b0;
                nx_flags[FLAG_H] = 1'b1;
            end
            ALU_CHG: begin
                rslt = cmd.op0;
                rslt[cmd.imm[3:0]] = ~cmd.op0[cmd.imm[3:0]];
            end
            ALU_BS1F: begin
                rslt = '0;
                for (int i = 15; i >= 0; i--) begin   // lowest set bit wins
                    if (cmd.op1[i])
                        rslt[3:0] = 4'(i);
                end
                nx_flags[FLAG_V] = cmd.op1[15:0] == 16'd0;
            end
            ALU_BS1B: begin
                rslt = '0;
                for (int i = 0; i < 16; i++) begin    // highest set bit wins
                    if (cmd.op1[i])
                        rslt[3:0] = 4'(i);
                end
                nx_flags[FLAG_V] = cmd.op1[15:0] == 16'd0;
            end
            ALU_MIRR: begin
                rslt = cmd.op0;
                for (int i = 0; i < 16; i++)
                    rslt[i] = cmd.op0[15-i];
            end
            ALU_EXTS: begin
                if (w == W_WORD)
                    rslt = {cmd.op0[31:16], {8{cmd.op0[7]}}, cmd.op0[7:0]};
                else
                    rslt = {{16{cmd.op0[15]}}, cmd.op0[15:0]};
            end
            ALU_EXTZ: begin
                if (w == W_WORD)
                    rslt = {cmd.op0[31:16], 8'd0, cmd.op0[7:0]};
                else
                    rslt = {16'd0, cmd.op0[15:0]};
            end
            ALU_CCF: begin
                nx_flags[FLAG_C] = ~flag_q[FLAG_C];
                nx_flags[FLAG_N] = 1'b0;
            end
            ALU_SCF, ALU_RCF: begin
                nx_flags[FLAG_C] = cmd.op == ALU_SCF;
                nx_flags[FLAG_N] = 1'b0;
                nx_flags[FLAG_H] = 1'b0;
            end
            ALU_DJNZ: begin
                // counter is a byte unless word is selected
                if (w == W_WORD) begin
                    rslt    = {cmd.op0[31:16], cmd.op0[15:0] - 16'd1};
                    nx_djnz = rslt[15:0] == 16'd0;
                end else begin
                    rslt    = {cmd.op0[31:8], cmd.op0[7:0] - 8'd1};
                    nx_djnz = rslt[7:0] == 8'd0;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result_q <= '0;
            flag_q   <= '0;
            djnz_q   <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            done_q <= cmd.start;
            if (cmd.start) begin
                result_q <= rslt;
                flag_q   <= nx_flags;
                djnz_q   <= nx_djnz;
            end
        end
    end

    assign cmd.result    = result_q;
    assign cmd.flags     = flag_q;
    assign cmd.djnz_zero = djnz_q;
    assign cmd.done      = done_q;

endmodule

//--- rtl/alu_unit.sv
`timescale 1ns/100ps
`include "alu_defs.svh"

module alu_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`ALU_ADDR_W-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`ALU_DATA_W-1:0]   wdata,
    input  logic [`ALU_DATA_W/8-1:0] wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [`ALU_ADDR_W-1:0]   araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [`ALU_DATA_W-1:0]   rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready
);

    alu_cmd_if cmd_if0 ();   // command and result path

    alu_regs regs0 (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .cmd     (cmd_if0.regs)
    );

    alu_core core0 (
        .clk (clk),
        .rst (rst),
        .cmd (cmd_if0.core)
    );

endmodule

//--- bench/alu_unit_tb.sv
`timescale 1ns/100ps
`include "alu_defs.svh"

module alu_unit_tb;
    import alu_pkg::*;

    localparam int limit = 50;   // cycles allowed per handshake wait

    localparam alu_op_e arith_ops [4] = '{ALU_ADD, ALU_SUB, ALU_CP, ALU_NEG};
    localparam alu_op_e logic_ops [4] = '{ALU_AND, ALU_OR, ALU_XOR, ALU_CPL};
    localparam alu_op_e chain_ops [10] = '{ALU_SCF, ALU_ADC, ALU_SBC, ALU_RCF, ALU_ADC,
                                           ALU_CCF, ALU_SBC, ALU_CCF, ALU_ADC, ALU_SBC};
    localparam alu_op_e bit_ops [8] = '{ALU_BS1F, ALU_BS1B, ALU_MIRR, ALU_EXTS,
                                        ALU_EXTZ, ALU_BIT, ALU_CHG, ALU_MOVE};

    logic                     clk;
    logic                     rst;
    logic [`ALU_ADDR_W-1:0]   awaddr;
    logic                     awvalid;
    logic                     awready;
    logic [`ALU_DATA_W-1:0]   wdata;
    logic [`ALU_DATA_W/8-1:0] wstrb;
    logic                     wvalid;
    logic                     wready;
    logic [1:0]               bresp;
    logic                     bvalid;
    logic                     bready;
    logic [`ALU_ADDR_W-1:0]   araddr;
    logic                     arvalid;
    logic                     arready;
    logic [`ALU_DATA_W-1:0]   rdata;
    logic [1:0]               rresp;
    logic                     rvalid;
    logic                     rready;

    integer      seed;
    logic [31:0] m_result;   // reference model state
    logic [7:0]  m_flags;
    logic        m_djnz;

    alu_unit dut0 (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    task automatic stop_run(input string why);
        $display("** FAIL **");
        $display("%s", why);
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        assert (act === exp) else
            stop_run($sformatf("CHECK FAILED at %0d ns: %s expected 0x%08h got 0x%08h",
                               $time, name, exp, act));
    endtask

    // hold > 0 keeps bready low for that many cycles
    task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
                             input int hold, output logic [1:0] resp);
        int n;
        int i;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        while (!(awready && wready)) begin
            @(negedge clk);
            n++;
            if (n > limit)
                stop_run($sformatf("timeout: write to 0x%02h never accepted, write FSM in %s",
                                   addr, dut0.regs0.wr_state.name()));
        end
        @(negedge clk);   // handshake taken on the last rising edge
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        while (!bvalid) begin
            @(negedge clk);
            n++;
            if (n > limit)
                stop_run($sformatf("timeout: no write response for 0x%02h, write FSM in %s",
                                   addr, dut0.regs0.wr_state.name()));
        end
        resp = bresp;
        for (i = 0; i < hold; i++) begin
            @(negedge clk);
            check_value("bvalid", bvalid, 1'b1);
            check_value("bresp", bresp, resp);
        end
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [4:0] addr, input int hold,
                            output logic [31:0] data, output logic [1:0] resp);
        int n;
        int i;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        while (!arready) begin
            @(negedge clk);
            n++;
            if (n > limit)
                stop_run($sformatf("timeout: read of 0x%02h never accepted, read FSM in %s",
                                   addr, dut0.regs0.rd_state.name()));
        end
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid) begin
            @(negedge clk);
            n++;
            if (n > limit)
                stop_run($sformatf("timeout: no read data for 0x%02h, read FSM in %s",
                                   addr, dut0.regs0.rd_state.name()));
        end
        data = rdata;
        resp = rresp;
        for (i = 0; i < hold; i++) begin   // rready held low
            @(negedge clk);
            check_value("rvalid", rvalid, 1'b1);
            check_value("rdata", rdata, data);
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic write_ok(input logic [4:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axi_write(addr, data, 0, resp);
        check_value("bresp", resp, `AXI_OKAY);
    endtask

    task automatic read_ok(input logic [4:0] addr, output logic [31:0] data);
        logic [1:0] resp;
        axi_read(addr, 0, data, resp);
        check_value("rresp", resp, `AXI_OKAY);
    endtask

    // behavioral model of one command
    task automatic model_exec(input alu_op_e op, input alu_width_e w, input logic sel,
                              input logic [31:0] a, input logic [31:0] b,
                              input logic [31:0] imm);
        logic [31:0] src, x, y, mask, r;
        logic [63:0] c, wide, nib;
        logic        sub, found;
        int          top, ones, i, j;
        src  = sel ? imm : b;
        top  = (w == W_BYTE) ? 7 : (w == W_WORD) ? 15 : 31;
        mask = (w == W_BYTE) ? 32'hFF : (w == W_WORD) ? 32'hFFFF : 32'hFFFF_FFFF;
        r    = m_result;
        case (op)
            ALU_MOVE: r = src;
            ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP, ALU_NEG: begin
                sub = !(op == ALU_ADD || op == ALU_ADC);
                c   = (op == ALU_ADC || op == ALU_SBC) ? {63'd0, m_flags[FLAG_C]} : 64'd0;
                x   = (op == ALU_NEG) ? 32'd0 : a;
                y   = (op == ALU_NEG) ? a : src;
                if (sub) begin
                    r    = x - y - c[31:0];
                    wide = {32'd0, x & mask} - {32'd0, y & mask} - c;   // borrow shows as high bits
                    nib  = {60'd0, x[3:0]} - {60'd0, y[3:0]} - c;
                    m_flags[FLAG_V] = (x[top] != y[top]) && (r[top] != x[top]);
                end else begin
                    r    = x + y + c[31:0];
                    wide = {32'd0, x & mask} + {32'd0, y & mask} + c;
                    nib  = {60'd0, x[3:0]} + {60'd0, y[3:0]} + c;
                    m_flags[FLAG_V] = (x[top] == y[top]) && (r[top] != x[top]);
                end
                m_flags[FLAG_C] = wide[top + 1];
                m_flags[FLAG_H] = nib[4];
                m_flags[FLAG_S] = r[top];
                m_flags[FLAG_Z] = (r & mask) == 32'd0;
                m_flags[FLAG_N] = sub;
                if (op == ALU_CP)
                    r = m_result;
            end
            ALU_AND, ALU_OR, ALU_XOR: begin
                r = (op == ALU_AND) ? (a & src) : (op == ALU_OR) ? (a | src) : (a ^ src);
                ones = 0;
                for (i = 0; i < 16; i++) begin
                    if (r[i] && (i < 8 || w != W_BYTE))
                        ones++;
                end
                m_flags[FLAG_V] = (ones % 2) == 0;
                m_flags[FLAG_S] = r[top];
                m_flags[FLAG_Z] = (r & mask) == 32'd0;
                m_flags[FLAG_H] = op == ALU_AND;
                m_flags[FLAG_N] = 1'b0;
                m_flags[FLAG_C] = 1'b0;
            end
            ALU_CPL: begin
                r = ~src;
                m_flags[FLAG_H] = 1'b1;
                m_flags[FLAG_N] = 1'b1;
            end
            ALU_BIT: begin
                m_flags[FLAG_Z] = !b[imm[3:0]];
                m_flags[FLAG_N] = 1'b0;
                m_flags[FLAG_H] = 1'b1;
            end
            ALU_CHG: r = a ^ (32'd1 << imm[3:0]);
            ALU_BS1F, ALU_BS1B: begin
                r = 32'd0;
                found = 1'b0;
                for (i = 0; i < 16; i++) begin
                    j = (op == ALU_BS1F) ? i : 15 - i;   // scan from the wanted end
                    if (b[j] && !found) begin
                        r = 32'(j);
                        found = 1'b1;
                    end
                end
                m_flags[FLAG_V] = b[15:0] == 16'd0;
            end
            ALU_MIRR: begin
                r = a;
                for (i = 0; i < 16; i++)
                    r[i] = a[15 - i];
            end
            ALU_EXTS: r = (w == W_WORD) ? {a[31:16], 16'($signed(a[7:0]))}
                                        : 32'($signed(a[15:0]));
            ALU_EXTZ: r = (w == W_WORD) ? {a[31:16], 16'(a[7:0])} : 32'(a[15:0]);
            ALU_CCF: begin
                m_flags[FLAG_C] = !m_flags[FLAG_C];
                m_flags[FLAG_N] = 1'b0;
            end
            ALU_SCF, ALU_RCF: begin
                m_flags[FLAG_C] = op == ALU_SCF;
                m_flags[FLAG_N] = 1'b0;
                m_flags[FLAG_H] = 1'b0;
            end
            ALU_DJNZ: begin
                r = a;
                if (w == W_WORD) begin
                    r[15:0] = a[15:0] - 16'd1;
                    m_djnz  = r[15:0] == 16'd0;
                end else begin
                    r[7:0] = a[7:0] - 8'd1;
                    m_djnz = r[7:0] == 8'd0;
                end
            end
            default: ;
        endcase
        m_result = r;
    endtask

    function automatic logic [31:0] pack_cmd(input alu_op_e op, input alu_width_e w,
                                             input logic sel);
        logic [31:0] word;
        word = 32'd0;
        word[`CMD_OP_LSB +: 6] = op;
        word[`CMD_W_LSB +: 2]  = w;
        word[`CMD_IMM_BIT]     = sel;
        return word;
    endfunction

    task automatic run_cmd(input alu_op_e op, input alu_width_e w, input logic sel,
                           input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] imm);
        logic [31:0] got;
        write_ok(`REG_OP0, a);
        write_ok(`REG_OP1, b);
        write_ok(`REG_IMM, imm);
        write_ok(`REG_CMD, pack_cmd(op, w, sel));
        model_exec(op, w, sel, a, b, imm);
        read_ok(`REG_RESULT, got);
        check_value($sformatf("RESULT after %s", op.name()), got, m_result);
        read_ok(`REG_FLAGS, got);
        check_value($sformatf("FLAGS after %s", op.name()), got, {24'd0, m_flags});
    endtask

    initial begin
        logic [31:0] got;
        logic [31:0] val;
        logic [1:0]  resp;
        int          k;
        int          i;
        seed     = 32'h740f8566;
        clk      = 1'b0;
        rst      = 1'b1;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        m_result = 32'd0;
        m_flags  = 8'd0;
        m_djnz   = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // a finished command leaves the sticky done bit set
        run_cmd(ALU_DJNZ, W_BYTE, 1'b0, 32'h1234_5605, rand32(), rand32());
        read_ok(`REG_STATUS, got);
        check_value("STATUS done", got[0], 1'b1);

        // next CMD write clears it before the core answers
        val = m_result;
        write_ok(`REG_OP0, val);
        fork
            write_ok(`REG_CMD, pack_cmd(ALU_DJNZ, W_BYTE, 1'b0));
            begin
                @(negedge clk);   // read address taken on the edge after the CMD handshake
                axi_read(`REG_STATUS, 0, got, resp);
            end
        join
        model_exec(ALU_DJNZ, W_BYTE, 1'b0, val, 32'd0, 32'd0);
        check_value("rresp", resp, `AXI_OKAY);
        check_value("STATUS done before response", got[0], 1'b0);
        read_ok(`REG_STATUS, got);
        check_value("STATUS done", got[0], 1'b1);
        while (m_result[7:0] != 8'd0) begin   // count down to zero
            run_cmd(ALU_DJNZ, W_BYTE, 1'b0, m_result, rand32(), rand32());
            read_ok(`REG_STATUS, got);
            check_value("STATUS djnz_zero", got[1], m_djnz);
            check_value("STATUS done", got[0], 1'b1);
        end

        for (k = 0; k < 3; k++) begin
            for (i = 0; i < 4; i++)
                run_cmd(arith_ops[i], alu_width_e'(2'(k)), rand32() > 32'h8000_0000,
                        rand32(), rand32(), rand32());
        end
        for (i = 0; i < 10; i++)   // carry handed from one command to the next
            run_cmd(chain_ops[i], alu_width_e'(2'(i % 3)), 1'b0, rand32(), rand32(),
                    rand32());
        for (k = 0; k < 6; k++) begin
            for (i = 0; i < 4; i++)
                run_cmd(logic_ops[i], alu_width_e'(2'(k % 3)), k >= 3,
                        rand32(), rand32(), rand32());
        end
        for (k = 0; k < 3; k++) begin
            for (i = 0; i < 8; i++)
                run_cmd(bit_ops[i], alu_width_e'(2'(k)), k == 1, rand32(), rand32(),
                        rand32());
        end
        run_cmd(ALU_BS1F, W_WORD, 1'b0, rand32(), 32'hABCD_0000, rand32());
        run_cmd(ALU_BS1B, W_WORD, 1'b0, rand32(), 32'hABCD_0000, rand32());

        // back-pressure on both channels
        val = rand32();
        axi_write(`REG_OP0, val, 4, resp);
        check_value("bresp", resp, `AXI_OKAY);
        axi_read(`REG_OP0, 4, got, resp);
        check_value("rresp", resp, `AXI_OKAY);
        check_value("OP0", got, val);
        axi_write(`REG_RESULT, ~m_result, 0, resp);
        check_value("bresp for RESULT write", resp, `AXI_SLVERR);
        read_ok(`REG_RESULT, got);
        check_value("RESULT after write attempt", got, m_result);
        axi_read(5'h1C, 0, got, resp);
        check_value("rresp for offset 0x1C", resp, `AXI_SLVERR);
        check_value("rdata for offset 0x1C", got, 32'd0);

        $display("** PASS **");
        $finish;
    end

endmodule

//--- alu_unit.f
+incdir+rtl
rtl/alu_pkg.sv
rtl/alu_cmd_if.sv
rtl/alu_regs.sv
rtl/alu_core.sv
rtl/alu_unit.sv
bench/alu_unit_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = alu_unit_tb
RTL_TOP  = alu_unit
FILELIST = alu_unit.f
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

lint:
	$(SIM) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
